/* lce_req_config.svh */
`ifndef LCE_REQ_CONFIG_SVH
`define LCE_REQ_CONFIG_SVH

// Coherence id widths
`define LCE_REQ_CCE_ID_W 3
`define LCE_REQ_LCE_ID_W 3

// Request body widths
`define LCE_REQ_PADDR_W 20
`define LCE_REQ_DATA_W 32

// One flit on the wormhole link
`define LCE_REQ_FLIT_W 16

// Router coordinate with y above x
`define LCE_REQ_CORD_X_W 4
`define LCE_REQ_CORD_Y_W 3

// Concentrator id and length header fields
`define LCE_REQ_CID_W 1
`define LCE_REQ_LEN_W 3

// Mesh shape as seen by the CCE tiles
`define LCE_REQ_MESH_COLS 2
`define LCE_REQ_CCE_Y_ORIGIN 1

`endif

/* lce_req_pkg.sv */
`include "lce_req_config.svh"

package lce_req_pkg;

  typedef logic [`LCE_REQ_CCE_ID_W-1:0] cce_id_t;
  typedef logic [`LCE_REQ_LCE_ID_W-1:0] lce_id_t;
  typedef logic [`LCE_REQ_PADDR_W-1:0] paddr_t;
  typedef logic [`LCE_REQ_DATA_W-1:0] req_data_t;
  typedef logic [`LCE_REQ_FLIT_W-1:0] flit_t;
  typedef logic [`LCE_REQ_CORD_Y_W+`LCE_REQ_CORD_X_W-1:0] cord_t;
  typedef logic [`LCE_REQ_CID_W-1:0] cid_t;
  typedef logic [`LCE_REQ_LEN_W-1:0] len_t;

  typedef enum logic [1:0] {
    e_lce_req_rd,
    e_lce_req_wr,
    e_lce_req_uc_rd,
    e_lce_req_uc_wr
  } lce_req_type_e;

  // {data, addr, src, dst, type}
  typedef logic [59:0] lce_req_payload_t;

  // {payload, len, cid, cord}
  typedef logic [70:0] lce_req_packet_t;

  localparam int LCE_REQ_PACKET_W = 71;

  // Header without the data field fits in three flits
  localparam len_t LCE_REQ_SHORT_LEN = 3'd2;
  localparam len_t LCE_REQ_FULL_LEN = 3'd4;

  // Position of the length field inside a packet
  localparam int LCE_REQ_LEN_LSB = $bits(cord_t) + $bits(cid_t);

endpackage

/* cce_id_to_cord.sv */
`include "lce_req_config.svh"

module cce_id_to_cord
  import lce_req_pkg::*;
(
  input  cce_id_t cce_id_i,
  output cord_t   cord_o,
  output cid_t    cid_o
);

  localparam int TILE_W = `LCE_REQ_CCE_ID_W - `LCE_REQ_CID_W;

  logic [TILE_W-1:0]           tile;
  logic [`LCE_REQ_CORD_X_W-1:0] cord_x;
  logic [`LCE_REQ_CORD_Y_W-1:0] cord_y;

  // Two CCEs share a tile through the concentrator
  assign cid_o = cce_id_i[`LCE_REQ_CID_W-1:0];
  assign tile  = cce_id_i[`LCE_REQ_CCE_ID_W-1:`LCE_REQ_CID_W];

  // Tiles fill rows left to right starting at the CCE origin row
  assign cord_x = `LCE_REQ_CORD_X_W'(tile % `LCE_REQ_MESH_COLS);
  assign cord_y = `LCE_REQ_CORD_Y_W'(`LCE_REQ_CCE_Y_ORIGIN + tile / `LCE_REQ_MESH_COLS);

  assign cord_o = {cord_y, cord_x};

endmodule

/* lce_req_encode.sv */
module lce_req_encode
  import lce_req_pkg::*;
(
  input  lce_req_type_e   msg_type_i,
  input  lce_id_t         src_id_i,
  input  cce_id_t         dst_id_i,
  input  paddr_t          addr_i,
  input  req_data_t       data_i,
  output lce_req_packet_t packet_o
);

  lce_req_payload_t payload;
  cord_t            dst_cord;
  cid_t             dst_cid;
  len_t             pkt_len;

  cce_id_to_cord u_cord (
    .cce_id_i (dst_id_i),
    .cord_o   (dst_cord),
    .cid_o    (dst_cid)
  );

  // Data always sits at the top so short packets just stop early
  assign payload = {data_i, addr_i, src_id_i, dst_id_i, msg_type_i};

  // Only uncached writes carry data flits
  always_comb begin
    case (msg_type_i)
      e_lce_req_uc_wr: pkt_len = LCE_REQ_FULL_LEN;
      e_lce_req_rd,
      e_lce_req_wr,
      e_lce_req_uc_rd: pkt_len = LCE_REQ_SHORT_LEN;
      default:         pkt_len = LCE_REQ_SHORT_LEN;
    endcase
  end

  assign packet_o = {payload, pkt_len, dst_cid, dst_cord};

endmodule

/* wormhole_flit_tx.sv */
`include "lce_req_config.svh"

module wormhole_flit_tx
  import lce_req_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  lce_req_packet_t packet_i,
  input  logic            packet_v_i,
  output logic            packet_ready_o,
  output flit_t           link_flit_o,
  output logic            link_v_o,
  input  logic            link_ready_i
);

  localparam int MAX_FLITS = int'(LCE_REQ_FULL_LEN) + 1;
  localparam int EXT_W     = MAX_FLITS * `LCE_REQ_FLIT_W;
  localparam int SHORT_W   = LCE_REQ_PACKET_W - `LCE_REQ_DATA_W;

  typedef enum logic {
    e_idle,
    e_send
  } tx_state_e;

  tx_state_e       state_r;
  lce_req_packet_t packet_r;
  len_t            cnt_r;
  len_t            pkt_len;
  logic [EXT_W-1:0] packet_ext;
  logic [EXT_W-1:0] keep_mask;
  logic            accept;
  logic            flit_done;

  assign packet_ready_o = (state_r == e_idle);
  assign link_v_o       = (state_r == e_send);

  assign accept    = packet_v_i & packet_ready_o;
  assign flit_done = link_v_o & link_ready_i;

  // Length comes from the captured header
  assign pkt_len = packet_r[LCE_REQ_LEN_LSB +: `LCE_REQ_LEN_W];

  // Short packets end below the data field, so nothing above it goes out
  assign keep_mask = (pkt_len == LCE_REQ_FULL_LEN) ? {EXT_W{1'b1}}
                   : {{(EXT_W-SHORT_W){1'b0}}, {SHORT_W{1'b1}}};

  // Last slice reads zeros past the packet end
  assign packet_ext  = {{(EXT_W-LCE_REQ_PACKET_W){1'b0}}, packet_r} & keep_mask;
  assign link_flit_o = packet_ext[cnt_r*`LCE_REQ_FLIT_W +: `LCE_REQ_FLIT_W];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      packet_r <= packet_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        e_idle: begin
          if (accept) begin
            state_r <= e_send;
            cnt_r   <= '0;
          end
        end
        e_send: begin
          if (flit_done) begin
            if (cnt_r == pkt_len) begin
              state_r <= e_idle;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
        end
        default: state_r <= e_idle;
      endcase
    end
  end

endmodule

/* wormhole_flit_rx.sv */
`include "lce_req_config.svh"

module wormhole_flit_rx
  import lce_req_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  flit_t         link_flit_i,
  input  logic          link_v_i,
  output logic          link_ready_o,
  output lce_req_type_e msg_type_o,
  output lce_id_t       src_id_o,
  output cce_id_t       dst_id_o,
  output paddr_t        addr_o,
  output req_data_t     data_o,
  output cord_t         cord_o,
  output cid_t          cid_o,
  output len_t          len_o,
  output logic          out_v_o,
  input  logic          out_yumi_i
);

  localparam int MAX_FLITS = int'(LCE_REQ_FULL_LEN) + 1;
  localparam int EXT_W     = MAX_FLITS * `LCE_REQ_FLIT_W;

  typedef enum logic [1:0] {
    e_header,
    e_body,
    e_full
  } rx_state_e;

  rx_state_e        state_r;
  lce_req_packet_t  packet_r;
  logic [EXT_W-1:0] packet_ext;
  logic [EXT_W-1:0] packet_n;
  len_t             cnt_r;
  len_t             hdr_len;
  len_t             pkt_len;
  logic             flit_take;
  lce_req_payload_t payload;
  logic [$bits(lce_req_type_e)-1:0] type_raw;

  assign link_ready_o = (state_r != e_full);
  assign out_v_o      = (state_r == e_full);
  assign flit_take    = link_v_i & link_ready_o;

  // Length read straight off the first flit, then from the stored header
  assign hdr_len = link_flit_i[LCE_REQ_LEN_LSB +: `LCE_REQ_LEN_W];
  assign pkt_len = packet_r[LCE_REQ_LEN_LSB +: `LCE_REQ_LEN_W];

  // Drop the incoming flit into its slice
  always_comb begin
    packet_ext = {{(EXT_W-LCE_REQ_PACKET_W){1'b0}}, packet_r};
    packet_n   = packet_ext;
    packet_n[cnt_r*`LCE_REQ_FLIT_W +: `LCE_REQ_FLIT_W] = link_flit_i;
  end

  // A new header wipes the register so unsent data reads as zero
  always_ff @(posedge clk_i) begin
    if (flit_take) begin
      if (state_r == e_header) begin
        packet_r <= LCE_REQ_PACKET_W'(link_flit_i);
      end else begin
        packet_r <= packet_n[LCE_REQ_PACKET_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_header;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        e_header: begin
          if (flit_take) begin
            cnt_r   <= 3'd1;
            state_r <= (hdr_len == '0) ? e_full : e_body;
          end
        end
        e_body: begin
          if (flit_take) begin
            cnt_r <= cnt_r + 1'b1;
            if (cnt_r == pkt_len) begin
              state_r <= e_full;
            end
          end
        end
        e_full: begin
          // Hold the packet until the consumer takes it
          if (out_yumi_i) begin
            state_r <= e_header;
            cnt_r   <= '0;
          end
        end
        default: state_r <= e_header;
      endcase
    end
  end

  assign {payload, len_o, cid_o, cord_o} = packet_r;
  assign {data_o, addr_o, src_id_o, dst_id_o, type_raw} = payload;
  assign msg_type_o = lce_req_type_e'(type_raw);

endmodule

/* lce_req_link_top.sv */
module lce_req_link_top
  import lce_req_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          req_v_i,
  output logic          req_ready_o,
  input  lce_req_type_e msg_type_i,
  input  lce_id_t       src_id_i,
  input  cce_id_t       dst_id_i,
  input  paddr_t        addr_i,
  input  req_data_t     data_i,
  output lce_req_type_e msg_type_o,
  output lce_id_t       src_id_o,
  output cce_id_t       dst_id_o,
  output paddr_t        addr_o,
  output req_data_t     data_o,
  output cord_t         cord_o,
  output cid_t          cid_o,
  output len_t          len_o,
  output logic          out_v_o,
  input  logic          out_yumi_i
);

  lce_req_packet_t req_packet;

  // Internal wormhole link
  flit_t link_flit;
  logic  link_v;
  logic  link_ready;

  lce_req_encode u_encode (
    .msg_type_i (msg_type_i),
    .src_id_i   (src_id_i),
    .dst_id_i   (dst_id_i),
    .addr_i     (addr_i),
    .data_i     (data_i),
    .packet_o   (req_packet)
  );

  wormhole_flit_tx u_tx (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .packet_i       (req_packet),
    .packet_v_i     (req_v_i),
    .packet_ready_o (req_ready_o),
    .link_flit_o    (link_flit),
    .link_v_o       (link_v),
    .link_ready_i   (link_ready)
  );

  wormhole_flit_rx u_rx (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .link_flit_i  (link_flit),
    .link_v_i     (link_v),
    .link_ready_o (link_ready),
    .msg_type_o   (msg_type_o),
    .src_id_o     (src_id_o),
    .dst_id_o     (dst_id_o),
    .addr_o       (addr_o),
    .data_o       (data_o),
    .cord_o       (cord_o),
    .cid_o        (cid_o),
    .len_o        (len_o),
    .out_v_o      (out_v_o),
    .out_yumi_i   (out_yumi_i)
  );

endmodule

/* tb_lce_req_link.sv */
`include "lce_req_config.svh"

module tb_lce_req_link
  import lce_req_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 200;

  typedef struct packed {
    logic [1:0] mtype;
    lce_id_t    src;
    cce_id_t    dst;
    paddr_t     addr;
    req_data_t  data;
  } req_s;

  logic clk_i = 1'b0;
  logic rst_n_i, req_v_i, req_ready_o, out_v_o, out_yumi_i;
  lce_req_type_e msg_type_i, msg_type_o;
  lce_id_t src_id_i, src_id_o;
  cce_id_t dst_id_i, dst_id_o;
  paddr_t addr_i, addr_o;
  req_data_t data_i, data_o;
  cord_t cord_o;
  cid_t cid_o;
  len_t len_o;

  int seed = 76973;
  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int failed_tests = 0;
  req_s sent_q[$];

  lce_req_link_top dut0 (.*);

  always #5 clk_i = ~clk_i;
  always @(posedge clk_i) cycle <= cycle + 1;

  // Tiles fill rows of the mesh from the CCE origin row, two CCEs per tile
  function automatic cord_t model_cord(input cce_id_t id);
    int tile;
    tile = int'(id) >> `LCE_REQ_CID_W;
    return {`LCE_REQ_CORD_Y_W'(`LCE_REQ_CCE_Y_ORIGIN + tile / `LCE_REQ_MESH_COLS),
            `LCE_REQ_CORD_X_W'(tile % `LCE_REQ_MESH_COLS)};
  endfunction

  function automatic bit is_uc_wr(input logic [1:0] t);
    return lce_req_type_e'(t) == e_lce_req_uc_wr;
  endfunction

  function automatic req_s rand_req();
    req_s r;
    r.mtype = 2'($random(seed));
    r.src   = `LCE_REQ_LCE_ID_W'($random(seed));
    r.dst   = `LCE_REQ_CCE_ID_W'($random(seed));
    r.addr  = `LCE_REQ_PADDR_W'($random(seed));
    r.data  = `LCE_REQ_DATA_W'($random(seed));
    return r;
  endfunction

  function automatic bit cond_met(input int which);
    case (which)
      0:       return req_ready_o;
      1:       return out_v_o;
      default: return !req_ready_o;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // 0 waits for ready, 1 for out_v, 2 for ready to drop
  task automatic wait_for(input int which, output bit ok);
    string names[3] = '{"req_ready_o rising", "out_v_o rising", "req_ready_o falling"};
    int n;
    n = 0;
    while (!cond_met(which) && n < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    ok = cond_met(which);
    assert (ok) else begin
      $display("Timeout at %0t: no %s within %0d cycles", $time, names[which], TIMEOUT);
      errors++;
    end
  endtask

  task automatic check_out(input req_s r);
    check_val("msg_type_o", 32'(msg_type_o), 32'(r.mtype));
    check_val("src_id_o", 32'(src_id_o), 32'(r.src));
    check_val("dst_id_o", 32'(dst_id_o), 32'(r.dst));
    check_val("addr_o", 32'(addr_o), 32'(r.addr));
    // Short packets never carry the data flits
    check_val("data_o", data_o, is_uc_wr(r.mtype) ? r.data : 32'd0);
    check_val("cord_o", 32'(cord_o), 32'(model_cord(r.dst)));
    check_val("cid_o", 32'(cid_o), 32'(r.dst[0]));
    check_val("len_o", 32'(len_o), is_uc_wr(r.mtype) ? 32'd4 : 32'd2);
  endtask

  // Returns the cycle in which the request was presented with ready high
  task automatic send_req(input req_s r, output int acc);
    bit ok;
    msg_type_i = lce_req_type_e'(r.mtype);
    src_id_i   = r.src;
    dst_id_i   = r.dst;
    addr_i     = r.addr;
    data_i     = r.data;
    req_v_i    = 1'b1;
    wait_for(0, ok);
    acc = cycle;
    if (ok) begin
      @(posedge clk_i);
      #1;
      sent_q.push_back(r);
    end
    req_v_i = 1'b0;
  endtask

  task automatic take_out(output bit ok);
    req_s r;
    wait_for(1, ok);
    if (ok) begin
      assert (sent_q.size() > 0) else begin
        $display("Output at %0t arrived with no request pending", $time);
        errors++;
      end
      if (sent_q.size() > 0) begin
        r = sent_q.pop_front();
        check_out(r);
      end
      out_yumi_i = 1'b1;
      @(posedge clk_i);
      #1;
      out_yumi_i = 1'b0;
    end
  endtask

  // out_v_o is due in cycle L+2 when the consumer never stalls
  task automatic single(input req_s r);
    int acc;
    bit ok;
    send_req(r, acc);
    wait_for(1, ok);
    check_val("latency", 32'(cycle - acc), is_uc_wr(r.mtype) ? 32'd6 : 32'd4);
    take_out(ok);
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    if (errors != err0) failed_tests++;
    $display("%s: %s", name, (errors == err0) ? "passed" : "failed");
  endtask

  initial begin
    req_s r;
    int err0;
    int acc;
    int got;
    bit ok;
    rst_n_i    = 1'b0;
    req_v_i    = 1'b0;
    msg_type_i = e_lce_req_rd;
    src_id_i   = '0;
    dst_id_i   = '0;
    addr_i     = '0;
    data_i     = '0;
    out_yumi_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    err0 = errors;
    check_val("req_ready_o", 32'(req_ready_o), 32'd1);
    check_val("out_v_o", 32'(out_v_o), 32'd0);
    end_test("reset_state", err0);

    err0 = errors;
    for (int t = 0; t < 4; t++) begin
      for (int d = 0; d < 8; d++) begin
        r = rand_req();
        r.mtype = 2'(t);
        r.dst = `LCE_REQ_CCE_ID_W'(d);
        single(r);
      end
    end
    end_test("types_and_ids", err0);

    // All-ones data makes a missed zero fill obvious
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      r = rand_req();
      r.mtype = 2'(i);
      if (i >= 8) r.data = '1;
      single(r);
    end
    end_test("data_and_latency", err0);

    // First packet held in the receiver, second stuck in the sender
    err0 = errors;
    send_req(rand_req(), acc);
    wait_for(1, ok);
    send_req(rand_req(), acc);
    wait_for(2, ok);
    repeat (20) begin
      @(posedge clk_i);
      #1;
    end
    check_val("req_ready_o", 32'(req_ready_o), 32'd0);
    take_out(ok);
    wait_for(0, ok);
    take_out(ok);
    end_test("back_pressure", err0);

    err0 = errors;
    got = 0;
    fork
      for (int i = 0; i < 300; i++) begin
        repeat ({$random(seed)} % 4) begin
          @(posedge clk_i);
          #1;
        end
        send_req(rand_req(), acc);
      end
      begin
        ok = 1'b1;
        while (got < 300 && ok) begin
          wait_for(1, ok);
          repeat ({$random(seed)} % 6) begin
            @(posedge clk_i);
            #1;
          end
          take_out(ok);
          got++;
        end
      end
    join
    check_val("requests left in model", 32'(sent_q.size()), 32'd0);
    end_test("random_traffic", err0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
lce_req_pkg.sv
cce_id_to_cord.sv
lce_req_encode.sv
wormhole_flit_tx.sv
wormhole_flit_rx.sv
lce_req_link_top.sv
tb_lce_req_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lce_req_link
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
